// ==== Makefile ====
# Verilator build and run for the modular-inverse engine

VERILATOR ?= verilator
TOP       ?= ntm_inverter_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FLIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Pass or fail is taken from the log, not the exit status
run: compile
	./$(BINARY) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/ntm_ctrl_pkg.sv ====
package ntm_ctrl_pkg;

  //////////////////////////////
  // Inverter FSM states
  //////////////////////////////

  typedef enum logic [2:0] {
    IDLE     = 3'd0,  // Waiting for a request
    TEST     = 3'd1,  // Decide the next step from the flags
    HALVE_U  = 3'd2,
    HALVE_V  = 3'd3,
    SUBTRACT = 3'd4,
    REDUCE   = 3'd5,  // Final reduction below m
    DONE     = 3'd6   // Response held until taken
  } inv_state_t;

  //////////////////////////////
  // Datapath control
  //////////////////////////////

  // One strobe per datapath operation
  typedef struct packed {
    logic load;
    logic halve_u;
    logic halve_v;
    logic subtract;
    logic reduce;
  } dp_cmd_t;

  // Status of the datapath registers
  typedef struct packed {
    logic u_one;
    logic v_one;
    logic u_zero;
    logic v_zero;
    logic u_even;
    logic v_even;
    logic res_ge_m;  // chosen result not yet below m
    logic mod_bad;   // loaded modulus unusable
    logic a_zero;    // loaded operand is zero
  } dp_flags_t;

endpackage

// ==== design/ntm_inverter_datapath.sv ====
module ntm_inverter_datapath (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  ntm_math_pkg::inv_req_t                 req,
  input  ntm_ctrl_pkg::dp_cmd_t                  cmd,
  output ntm_ctrl_pkg::dp_flags_t                flags,
  output logic [ntm_math_pkg::NTM_DATA_SIZE-1:0] result
);
  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;

  // One guard bit above the data for the x and y sums
  localparam int W = NTM_DATA_SIZE + 1;

  logic [W-1:0]             u_q;
  logic [W-1:0]             v_q;
  logic [W-1:0]             x_q;
  logic [W-1:0]             y_q;
  logic [NTM_DATA_SIZE-1:0] m_q;
  logic [W-1:0]             m_ext;
  logic [W-1:0]             chosen;
  logic                     mod_bad_q;
  logic                     a_zero_q;

  assign m_ext = {1'b0, m_q};

  // x goes with u, y with v
  assign chosen = flags.u_one ? x_q : y_q;

  //////////////////////////////
  // Flags
  //////////////////////////////

  assign flags.u_one    = (u_q == W'(1));
  assign flags.v_one    = (v_q == W'(1));
  assign flags.u_zero   = (u_q == '0);
  assign flags.v_zero   = (v_q == '0);
  assign flags.u_even   = ~u_q[0];
  assign flags.v_even   = ~v_q[0];
  assign flags.res_ge_m = (chosen >= m_ext);
  assign flags.mod_bad  = mod_bad_q;
  assign flags.a_zero   = a_zero_q;

  //////////////////////////////
  // Working registers
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (cmd.load) begin
      u_q <= {1'b0, req.operand};
      v_q <= {1'b0, req.modulus};
      m_q <= req.modulus;
      x_q <= W'(1);
      y_q <= '0;
    end else if (cmd.halve_u) begin
      u_q <= u_q >> 1;
      // Odd x made even by adding m
      x_q <= x_q[0] ? (x_q + m_ext) >> 1 : x_q >> 1;
    end else if (cmd.halve_v) begin
      v_q <= v_q >> 1;
      y_q <= y_q[0] ? (y_q + m_ext) >> 1 : y_q >> 1;
    end else if (cmd.subtract) begin
      // Equal u and v reduce u
      if (u_q >= v_q) begin
        u_q <= u_q - v_q;
        x_q <= (x_q >= y_q) ? x_q - y_q : x_q - y_q + m_ext;
      end else begin
        v_q <= v_q - u_q;
        y_q <= (y_q >= x_q) ? y_q - x_q : y_q - x_q + m_ext;
      end
    end else if (cmd.reduce && flags.res_ge_m) begin
      if (flags.u_one) begin
        x_q <= x_q - m_ext;
      end else begin
        y_q <= y_q - m_ext;
      end
    end
  end

  //////////////////////////////
  // Request flags and result
  //////////////////////////////

  // Result stays zero unless the reduction completes
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mod_bad_q <= 1'b0;
      a_zero_q  <= 1'b0;
      result    <= '0;
    end else if (cmd.load) begin
      mod_bad_q <= ~req.modulus[0] || (req.modulus < NTM_DATA_SIZE'(3));
      a_zero_q  <= (req.operand == '0);
      result    <= '0;
    end else if (cmd.reduce && !flags.res_ge_m) begin
      result <= chosen[NTM_DATA_SIZE-1:0];
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // FSM issues one operation per cycle
  a_cmd_onehot: assert property (@(posedge CLK) disable iff (RST)
    $onehot0(cmd));

  // Halving adds m to odd values, exact only for an odd m
  a_mod_odd: assert property (@(posedge CLK) disable iff (RST)
    (cmd.halve_u || cmd.halve_v) |-> m_q[0]);

endmodule

// ==== design/ntm_inverter_fsm.sv ====
module ntm_inverter_fsm (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      req_valid,
  output logic                      req_ready,
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  input  ntm_ctrl_pkg::dp_flags_t   flags,
  output ntm_ctrl_pkg::dp_cmd_t     cmd,
  output logic                      clear,
  output logic                      count,
  input  logic                      limit_hit,
  output ntm_math_pkg::inv_status_t status
);
  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;

  inv_state_t  state_q;
  inv_state_t  state_d;
  inv_status_t status_d;

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  // Not ready while reset is held
  assign req_ready = (state_q == IDLE) && !RST;
  assign rsp_valid = (state_q == DONE);

  // Counter restarts on accept, steps on each subtraction
  assign clear = req_ready && req_valid;
  assign count = (state_q == SUBTRACT);

  //////////////////////////////
  // Next state and strobes
  //////////////////////////////

  always_comb begin
    state_d  = state_q;
    status_d = status;
    cmd      = '0;
    case (state_q)
      IDLE: begin
        if (req_valid && req_ready) begin
          cmd.load = 1'b1;
          state_d  = TEST;
        end
      end
      TEST: begin
        // Priority order of the checks matters here
        if (flags.mod_bad) begin
          status_d = STATUS_BAD_MODULUS;
          state_d  = DONE;
        end else if (flags.a_zero) begin
          status_d = STATUS_NO_INVERSE;
          state_d  = DONE;
        end else if (flags.u_one || flags.v_one) begin
          state_d = REDUCE;
        end else if (flags.u_zero || flags.v_zero) begin
          // gcd above one
          status_d = STATUS_NO_INVERSE;
          state_d  = DONE;
        end else if (flags.u_even) begin
          state_d = HALVE_U;
        end else if (flags.v_even) begin
          state_d = HALVE_V;
        end else begin
          state_d = SUBTRACT;
        end
      end
      HALVE_U: begin
        cmd.halve_u = 1'b1;
        state_d     = TEST;
      end
      HALVE_V: begin
        cmd.halve_v = 1'b1;
        state_d     = TEST;
      end
      SUBTRACT: begin
        cmd.subtract = 1'b1;
        // Last allowed step
        if (limit_hit) begin
          status_d = STATUS_TIMEOUT;
          state_d  = DONE;
        end else begin
          state_d = TEST;
        end
      end
      REDUCE: begin
        // Datapath subtracts m or captures the result
        cmd.reduce = 1'b1;
        if (!flags.res_ge_m) begin
          status_d = STATUS_OK;
          state_d  = DONE;
        end
      end
      DONE: begin
        if (rsp_ready) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= IDLE;
      status  <= STATUS_OK;
    end else begin
      state_q <= state_d;
      status  <= status_d;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Response held under back-pressure
  a_status_hold: assert property (@(posedge CLK) disable iff (RST)
    rsp_valid && !rsp_ready |=> $stable(status));

  // No new request while a response is pending
  a_one_in_flight: assert property (@(posedge CLK) disable iff (RST)
    !(req_ready && rsp_valid));

endmodule

// ==== design/ntm_math_pkg.sv ====
package ntm_math_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Operand and modulus width
  localparam int NTM_DATA_SIZE = 32;

  // Subtraction step count width
  localparam int NTM_STEP_WIDTH = 8;

  //////////////////////////////
  // Status codes
  //////////////////////////////

  typedef enum logic [1:0] {
    STATUS_OK          = 2'd0,  // Result valid
    STATUS_BAD_MODULUS = 2'd1,  // Even modulus or below 3
    STATUS_NO_INVERSE  = 2'd2,  // Zero operand or common factor with m
    STATUS_TIMEOUT     = 2'd3   // Step bound reached
  } inv_status_t;

  //////////////////////////////
  // Request and response
  //////////////////////////////

  // Request word, 64 bits
  typedef struct packed {
    logic [NTM_DATA_SIZE-1:0] modulus;
    logic [NTM_DATA_SIZE-1:0] operand;
  } inv_req_t;

  // Response word, 42 bits
  typedef struct packed {
    logic [NTM_DATA_SIZE-1:0]  result;
    logic [NTM_STEP_WIDTH-1:0] steps;
    inv_status_t               status;
  } inv_rsp_t;

endpackage

// ==== design/ntm_scalar_inverter.sv ====
module ntm_scalar_inverter #(
  parameter int MAX_STEPS = 64
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  ntm_math_pkg::inv_req_t req,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output ntm_math_pkg::inv_rsp_t rsp
);
  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;

  dp_cmd_t                   cmd;
  dp_flags_t                 flags;
  logic                      clear;
  logic                      count;
  logic                      limit_hit;
  logic [NTM_STEP_WIDTH-1:0] steps;
  logic [NTM_DATA_SIZE-1:0]  result;
  inv_status_t               status;

  //////////////////////////////
  // Control
  //////////////////////////////

  ntm_inverter_fsm u_fsm (
    .CLK       (CLK),
    .RST       (RST),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .flags     (flags),
    .cmd       (cmd),
    .clear     (clear),
    .count     (count),
    .limit_hit (limit_hit),
    .status    (status)
  );

  // Bound on subtraction steps
  ntm_step_counter #(
    .MAX_STEPS (MAX_STEPS)
  ) u_counter (
    .CLK       (CLK),
    .RST       (RST),
    .clear     (clear),
    .count     (count),
    .steps     (steps),
    .limit_hit (limit_hit)
  );

  //////////////////////////////
  // Arithmetic
  //////////////////////////////

  ntm_inverter_datapath u_datapath (
    .CLK    (CLK),
    .RST    (RST),
    .req    (req),
    .cmd    (cmd),
    .flags  (flags),
    .result (result)
  );

  // Response word
  assign rsp = {result, steps, status};

endmodule

// ==== design/ntm_step_counter.sv ====
module ntm_step_counter #(
  parameter int MAX_STEPS = 64
) (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic                                    clear,
  input  logic                                    count,
  output logic [ntm_math_pkg::NTM_STEP_WIDTH-1:0] steps,
  output logic                                    limit_hit
);
  import ntm_math_pkg::*;

  // Count value just before the bound
  localparam logic [NTM_STEP_WIDTH-1:0] STEP_LAST = NTM_STEP_WIDTH'(MAX_STEPS - 1);

  //////////////////////////////
  // Step count
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      steps <= '0;
    end else if (clear) begin
      steps <= '0;
    end else if (count) begin
      steps <= steps + 1'b1;
    end
  end

  // This increment lands on MAX_STEPS
  assign limit_hit = count && (steps == STEP_LAST);

  //////////////////////////////
  // Checks
  //////////////////////////////

  // FSM must stop stepping at the bound
  a_steps_bound: assert property (@(posedge CLK) disable iff (RST)
    steps <= MAX_STEPS);

endmodule

// ==== flist.f ====
design/ntm_math_pkg.sv
design/ntm_ctrl_pkg.sv
design/ntm_inverter_fsm.sv
design/ntm_step_counter.sv
design/ntm_inverter_datapath.sv
design/ntm_scalar_inverter.sv
sim/ntm_inverter_checker.sv
sim/ntm_inverter_tb.sv

// ==== sim/ntm_inverter_checker.sv ====
module ntm_inverter_checker #(
  parameter int MAX_STEPS = 16,
  parameter int NAME_BITS = 128
) (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      req_valid,
  input  logic                      req_ready,
  input  ntm_math_pkg::inv_req_t    req,
  input  logic [NAME_BITS-1:0]      req_name,
  input  ntm_math_pkg::inv_status_t req_status,
  input  logic                      rsp_valid,
  input  logic                      rsp_ready,
  input  ntm_math_pkg::inv_rsp_t    rsp,
  output int                        pass_count,
  output int                        fail_count,
  output int                        error_count,
  output int                        rsp_count,
  output int                        pending
);
  timeunit 1ns;
  timeprecision 1ps;
  import ntm_math_pkg::*;

  // Accepted requests waiting for their response
  inv_req_t             req_q[$];
  logic [NAME_BITS-1:0] name_q[$];
  inv_status_t          status_q[$];

  // Response seen under back-pressure on the last edge
  bit       hold_active;
  inv_rsp_t hold_rsp;
  bit       reset_checked;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Binary extended Euclid, x tracks u and y tracks v modulo m
  task automatic model_inverse(input longint unsigned m, input longint unsigned a,
                               output inv_status_t st, output longint unsigned res,
                               output int steps);
    longint unsigned u;
    longint unsigned v;
    longint unsigned x;
    longint unsigned y;
    bit              busy;
    st    = STATUS_OK;
    res   = 0;
    steps = 0;
    u     = a;
    v     = m;
    x     = 1;
    y     = 0;
    busy  = 1'b1;
    // Request screening
    if (m % 2 == 0 || m < 3) begin
      st   = STATUS_BAD_MODULUS;
      busy = 1'b0;
    end else if (a == 0) begin
      st   = STATUS_NO_INVERSE;
      busy = 1'b0;
    end
    while (busy) begin
      if (u == 1 || v == 1) begin
        res = (u == 1) ? x : y;
        // Final reduction below m
        while (res >= m) begin
          res = res - m;
        end
        busy = 1'b0;
      end else if (u == 0 || v == 0) begin
        st   = STATUS_NO_INVERSE;
        busy = 1'b0;
      end else if (u % 2 == 0) begin
        u = u / 2;
        x = (x % 2 == 1) ? (x + m) / 2 : x / 2;
      end else if (v % 2 == 0) begin
        v = v / 2;
        y = (y % 2 == 1) ? (y + m) / 2 : y / 2;
      end else begin
        // Equal values reduce u
        if (u >= v) begin
          u = u - v;
          x = (x >= y) ? x - y : x + m - y;
        end else begin
          v = v - u;
          y = (y >= x) ? y - x : y + m - x;
        end
        steps++;
        if (steps == MAX_STEPS) begin
          st   = STATUS_TIMEOUT;
          res  = 0;
          busy = 1'b0;
        end
      end
    end
  endtask

  //////////////////////////////
  // Response compare
  //////////////////////////////

  task automatic check_response();
    inv_req_t             r;
    logic [NAME_BITS-1:0] nm;
    inv_status_t          tbl_st;
    inv_status_t          st;
    longint unsigned      res;
    longint unsigned      prod;
    int                   steps;
    inv_rsp_t             exp;
    rsp_count++;
    if (req_q.size() == 0) begin
      error_count++;
      $display("ERROR: response transferred with no request outstanding");
      return;
    end
    r      = req_q.pop_front();
    nm     = name_q.pop_front();
    tbl_st = status_q.pop_front();
    model_inverse(r.modulus, r.operand, st, res, steps);
    exp.result = res[NTM_DATA_SIZE-1:0];
    exp.steps  = NTM_STEP_WIDTH'(steps);
    exp.status = st;
    // Independent check of the inverse itself
    prod = 64'd0;
    if (st == STATUS_OK) begin
      prod = (64'(rsp.result) * 64'(r.operand)) % 64'(r.modulus);
    end
    if (rsp !== exp) begin
      fail_count++;
      $write("FAIL %0s expected result=%0d steps=%0d status=%s ",
             nm, exp.result, exp.steps, exp.status.name());
      $display("actual result=%0d steps=%0d status=%s",
               rsp.result, rsp.steps, rsp.status.name());
    end else if (st == STATUS_OK && prod != 64'd1) begin
      fail_count++;
      $display("FAIL %0s result*a mod m expected 1 actual %0d", nm, prod);
    end else if (rsp.status !== tbl_st) begin
      fail_count++;
      $display("FAIL %0s status expected %s actual %s", nm, tbl_st.name(), rsp.status.name());
    end else begin
      pass_count++;
      $display("PASS %0s result=%0d steps=%0d status=%s",
               nm, rsp.result, rsp.steps, rsp.status.name());
    end
  endtask

  //////////////////////////////
  // Port monitor
  //////////////////////////////

  always @(posedge CLK) begin
    if (RST) begin
      hold_active = 1'b0;
      if (rsp_valid !== 1'b0) begin
        error_count++;
        $display("ERROR: rsp_valid is not low during reset");
      end
      if (req_ready !== 1'b0) begin
        error_count++;
        $display("ERROR: req_ready is not low during reset");
      end
    end else begin
      // Idle handshake state right after reset
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (req_ready === 1'b1 && rsp_valid === 1'b0) begin
          pass_count++;
          $display("PASS reset_state req_ready high and rsp_valid low");
        end else begin
          fail_count++;
          $display("FAIL reset_state expected ready=1 valid=0 actual ready=%b valid=%b",
                   req_ready, rsp_valid);
        end
      end
      if (hold_active) begin
        if (rsp_valid !== 1'b1) begin
          error_count++;
          $display("ERROR: response withdrawn before it was taken");
        end else if (rsp !== hold_rsp) begin
          error_count++;
          $display("ERROR: response changed while rsp_ready was low");
        end
        if (req_ready !== 1'b0) begin
          error_count++;
          $display("ERROR: req_ready high while a response is pending");
        end
      end
      if (req_valid && req_ready) begin
        req_q.push_back(req);
        name_q.push_back(req_name);
        status_q.push_back(req_status);
      end
      if (rsp_valid && rsp_ready) begin
        check_response();
      end
      hold_active = rsp_valid && !rsp_ready;
      hold_rsp    = rsp;
    end
    pending = req_q.size();
  end

endmodule

// ==== sim/ntm_inverter_tb.sv ====
module ntm_inverter_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ntm_math_pkg::*;

  localparam int MAX_STEPS  = 16;
  localparam int NAME_BITS  = 8 * 16;
  // Cycles allowed for any single wait
  localparam int WAIT_LIMIT = 400;

  // One table row, expected status derived by hand from the rules
  typedef struct packed {
    logic [NAME_BITS-1:0] name;
    inv_status_t          status;
    inv_req_t             req;
  } vector_t;

  logic                 CLK;
  logic                 RST;
  logic                 req_valid;
  logic                 req_ready;
  inv_req_t             req;
  logic                 rsp_valid;
  logic                 rsp_ready;
  inv_rsp_t             rsp;
  logic [NAME_BITS-1:0] req_name;
  inv_status_t          req_status;
  int                   pass_count;
  int                   fail_count;
  int                   error_count;
  int                   rsp_count;
  int                   pending;
  vector_t              vectors[$];
  logic [31:0]          rnd;
  bit                   timed_out;

  ntm_scalar_inverter #(
    .MAX_STEPS (MAX_STEPS)
  ) u_dut (
    .CLK       (CLK),
    .RST       (RST),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  ntm_inverter_checker #(
    .MAX_STEPS (MAX_STEPS),
    .NAME_BITS (NAME_BITS)
  ) u_checker (
    .CLK         (CLK),
    .RST         (RST),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req         (req),
    .req_name    (req_name),
    .req_status  (req_status),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp         (rsp),
    .pass_count  (pass_count),
    .fail_count  (fail_count),
    .error_count (error_count),
    .rsp_count   (rsp_count),
    .pending     (pending)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] t;
    t = s ^ (s << 13);
    t = t ^ (t >> 17);
    t = t ^ (t << 5);
    return t;
  endfunction

  task automatic add_vector(input logic [NAME_BITS-1:0] name, input inv_status_t status,
                            input logic [31:0] modulus, input logic [31:0] operand);
    vector_t vec;
    vec.name        = name;
    vec.status      = status;
    vec.req.modulus = modulus;
    vec.req.operand = operand;
    vectors.push_back(vec);
  endtask

  task automatic build_table();
    // Coprime pairs
    add_vector("mod97_a5", STATUS_OK, 32'd97, 32'd5);
    add_vector("mod97_a1", STATUS_OK, 32'd97, 32'd1);
    add_vector("mod97_a200", STATUS_OK, 32'd97, 32'd200);
    add_vector("mod3_a2", STATUS_OK, 32'd3, 32'd2);
    // Largest 32-bit prime, halving only
    add_vector("prime_a2", STATUS_OK, 32'hFFFFFFFB, 32'd2);
    add_vector("prime_a2p31", STATUS_OK, 32'hFFFFFFFB, 32'h80000000);
    // Screened requests
    add_vector("even_modulus", STATUS_BAD_MODULUS, 32'd100, 32'd3);
    add_vector("modulus_one", STATUS_BAD_MODULUS, 32'd1, 32'd1);
    add_vector("modulus_zero", STATUS_BAD_MODULUS, 32'd0, 32'd5);
    add_vector("bad_and_zero", STATUS_BAD_MODULUS, 32'd100, 32'd0);
    add_vector("zero_operand", STATUS_NO_INVERSE, 32'd97, 32'd0);
    // Common factor found on a zero register
    add_vector("mod21_a14", STATUS_NO_INVERSE, 32'd21, 32'd14);
    add_vector("mod15_a15", STATUS_NO_INVERSE, 32'd15, 32'd15);
    // Exactly 16 steps, then about 30
    add_vector("limit_exact", STATUS_TIMEOUT, 32'hFFFFFFFB, 32'h7FFFFFFF);
    add_vector("limit_long", STATUS_TIMEOUT, 32'hFFFFFFFD, 32'd3);
  endtask

  //////////////////////////////
  // Request and response loops
  //////////////////////////////

  // Called on a falling edge, returns on the one after the accept
  task automatic send_request(input vector_t vec, output bit ok);
    int n;
    ok         = 1'b0;
    req        = vec.req;
    req_name   = vec.name;
    req_status = vec.status;
    req_valid  = 1'b1;
    for (n = 0; n < WAIT_LIMIT && !ok && !timed_out; n++) begin
      // Ready is stable here, so the next rising edge accepts
      if (req_ready) begin
        ok = 1'b1;
      end
      @(negedge CLK);
    end
    req_valid = 1'b0;
  endtask

  task automatic drive_requests();
    bit ok;
    foreach (vectors[i]) begin
      if (!timed_out) begin
        send_request(vectors[i], ok);
        if (!ok && !timed_out) begin
          timed_out = 1'b1;
          $display("Timeout: request %0s not accepted within %0d cycles",
                   vectors[i].name, WAIT_LIMIT);
        end
      end
    end
  endtask

  task automatic drain_responses();
    int k;
    int n;
    int hold;
    bit seen;
    for (k = 0; k < vectors.size() && !timed_out; k++) begin
      seen = 1'b0;
      for (n = 0; n < WAIT_LIMIT && !seen && !timed_out; n++) begin
        if (rsp_valid) begin
          seen = 1'b1;
        end else begin
          @(negedge CLK);
        end
      end
      if (seen) begin
        // Random back-pressure of 1 to 4 cycles
        rnd  = xorshift32(rnd);
        hold = int'(rnd[1:0]) + 1;
        repeat (hold) @(negedge CLK);
        rsp_ready = 1'b1;
        @(negedge CLK);
        rsp_ready = 1'b0;
      end else if (!timed_out) begin
        timed_out = 1'b1;
        $display("Timeout: response %0d not valid within %0d cycles", k, WAIT_LIMIT);
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    CLK        = 1'b0;
    RST        = 1'b1;
    req_valid  = 1'b0;
    req        = '0;
    rsp_ready  = 1'b0;
    req_name   = '0;
    req_status = STATUS_OK;
    rnd        = 32'h98486085;
    timed_out  = 1'b0;
    build_table();
    repeat (4) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    fork
      drive_requests();
      drain_responses();
    join
    repeat (2) @(negedge CLK);
    if (rsp_count != vectors.size() || pending != 0) begin
      $display("Error: %0d responses for %0d requests, %0d still pending",
               rsp_count, vectors.size(), pending);
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d other errors",
             pass_count + fail_count, pass_count, fail_count, error_count);
    if (timed_out || fail_count != 0 || error_count != 0 ||
        rsp_count != vectors.size() || pending != 0) begin
      $display("Test failures found");
    end else begin
      $display("All tests passed!");
    end
    $finish;
  end

endmodule
